// File: logic/io_gpio.sv
// GPIO block
// Output and enable registers, synchronized inputs and a masked
// rising-edge interrupt
`timescale 1ns/1ps
`default_nettype none
`include "io_params.svh"

module io_gpio import io_pkg::*; (
   input  wire                  clk,
   input  wire                  i_arst_n,
   input  wire wb_m2s_t         i_wb,
   input  wire                  i_stb,
   output wb_s2m_t              o_wb,
   input  wire [`IO_GPIO_W-1:0] i_gpio_in,
   output logic [`IO_GPIO_W-1:0] o_gpio_out,
   output logic [`IO_GPIO_W-1:0] o_gpio_oe,
   output logic                 o_gpio_irq
);

   logic [`IO_GPIO_W-1:0] sync1_q;
   logic [`IO_GPIO_W-1:0] sync2_q;
   logic [`IO_GPIO_W-1:0] prev_q;
   logic [`IO_GPIO_W-1:0] out_q;
   logic [`IO_GPIO_W-1:0] oe_q;
   logic [`IO_GPIO_W-1:0] mask_q;
   logic [`IO_GPIO_W-1:0] status_q;
   logic [`IO_GPIO_W-1:0] status_d;
   logic [`IO_GPIO_W-1:0] clr;
   logic                  irq_q;
   logic                  ack_q;
   logic [`IO_DW-1:0]     rdata_q;
   logic [`IO_DW-1:0]     rd_mux;
   logic                  acc;
   logic                  wr_en;

   assign acc   = i_wb.cyc && i_stb && !ack_q;
   assign wr_en = acc && i_wb.we;

   // Write one to clear, new edges win
   always_comb begin
      clr = '0;
      if (wr_en && (i_wb.adr.f.reg_idx == `GPIO_STATUS)) begin
         clr = strb_merge('0, i_wb.dat, i_wb.sel);
      end
      status_d = (status_q & ~clr) | (sync2_q & ~prev_q & mask_q);
   end

   always_comb begin
      case (i_wb.adr.f.reg_idx)
         `GPIO_IN:     rd_mux = sync2_q;
         `GPIO_OUT:    rd_mux = out_q;
         `GPIO_OE:     rd_mux = oe_q;
         `GPIO_MASK:   rd_mux = mask_q;
         `GPIO_STATUS: rd_mux = status_q;
         default:      rd_mux = '0;
      endcase
   end

   //*************************************************************************
   // Registers
   //*************************************************************************
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         sync1_q  <= '0;
         sync2_q  <= '0;
         prev_q   <= '0;
         out_q    <= '0;
         oe_q     <= '0;
         mask_q   <= '0;
         status_q <= '0;
         irq_q    <= 1'b0;
         ack_q    <= 1'b0;
      end else begin
         sync1_q  <= i_gpio_in;
         sync2_q  <= sync1_q;
         prev_q   <= sync2_q;
         status_q <= status_d;
         irq_q    <= |status_d;
         ack_q    <= acc;
         if (wr_en) begin
            case (i_wb.adr.f.reg_idx)
               `GPIO_OUT:  out_q  <= strb_merge(out_q, i_wb.dat, i_wb.sel);
               `GPIO_OE:   oe_q   <= strb_merge(oe_q, i_wb.dat, i_wb.sel);
               `GPIO_MASK: mask_q <= strb_merge(mask_q, i_wb.dat, i_wb.sel);
               default: begin
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (acc) begin
         rdata_q <= rd_mux;
      end
   end

   assign o_wb       = '{dat: rdata_q, ack: ack_q, err: 1'b0};
   assign o_gpio_out = out_q;
   assign o_gpio_oe  = oe_q;
   assign o_gpio_irq = irq_q;

endmodule

`default_nettype wire

// File: logic/io_params.svh
// I/O subsystem parameters
// Bus widths, address map, register offsets and the identification word
`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// Bus widths
`define IO_AW        16
`define IO_DW        32
`define IO_SW        (`IO_DW / 8)
`define IO_GPIO_W    32
`define IO_PAGE_W    4
`define IO_REG_W     4

// Peripheral pages
`define IO_PAGE_SYSCON  4'd0
`define IO_PAGE_GPIO    4'd1

// Syscon word offsets
`define SYS_ID          4'd0
`define SYS_STATUS      4'd1
`define SYS_SWIRQ       4'd2
`define SYS_MTIME       4'd3
`define SYS_MTIMECMP    4'd4

// GPIO word offsets
`define GPIO_IN         4'd0
`define GPIO_OUT        4'd1
`define GPIO_OE         4'd2
`define GPIO_MASK       4'd3
`define GPIO_STATUS     4'd4

`define SYS_ID_VALUE    32'h5753_0101

`endif

// File: logic/io_pkg.sv
// I/O subsystem types
// Host request and response, Wishbone channels, interrupt lines
`default_nettype none
`include "io_params.svh"

package io_pkg;

   typedef struct packed {
      logic [`IO_PAGE_W-1:0]                   page;
      logic [`IO_AW-`IO_PAGE_W-`IO_REG_W-3:0] spare;
      logic [`IO_REG_W-1:0]                    reg_idx;
      logic [1:0]                               byte_ofs;
   } io_addr_f_t;

   // Page is decoded by the bus decoder, register index by the slaves
   typedef union packed {
      logic [`IO_AW-1:0] raw;
      io_addr_f_t        f;
   } io_addr_u;

   typedef struct packed {
      logic              we;
      io_addr_u          addr;
      logic [`IO_DW-1:0] wdata;
      logic [`IO_SW-1:0] wstrb;
   } io_req_t;

   typedef struct packed {
      logic [`IO_DW-1:0] rdata;
      logic              err;
   } io_rsp_t;

   typedef struct packed {
      io_addr_u          adr;
      logic [`IO_DW-1:0] dat;
      logic [`IO_SW-1:0] sel;
      logic              we;
      logic              cyc;
      logic              stb;
   } wb_m2s_t;

   typedef struct packed {
      logic [`IO_DW-1:0] dat;
      logic              ack;
      logic              err;
   } wb_s2m_t;

   typedef struct packed {
      logic timer;
      logic sw3;
      logic sw4;
      logic gpio;
   } io_irq_t;

   // Byte lanes of new_val replace old_val where sel is set
   function automatic logic [`IO_DW-1:0] strb_merge(input logic [`IO_DW-1:0] old_val,
                                                    input logic [`IO_DW-1:0] new_val,
                                                    input logic [`IO_SW-1:0] sel);
      logic [`IO_DW-1:0] res;
      res = old_val;
      for (int i = 0; i < `IO_SW; i++) begin
         if (sel[i]) begin
            res[8*i +: 8] = new_val[8*i +: 8];
         end
      end
      return res;
   endfunction

endpackage

`default_nettype wire

// File: logic/io_soc_top.sv
// I/O subsystem top level
// Host request port bridged onto Wishbone, with syscon and GPIO slaves
`timescale 1ns/1ps
`default_nettype none
`include "io_params.svh"

module io_soc_top import io_pkg::*; (
   input  wire                   clk,
   input  wire                   i_arst_n,
   input  wire                   i_req_valid,
   input  wire io_req_t          i_req,
   output logic                  o_req_ready,
   output logic                  o_rsp_valid,
   output io_rsp_t               o_rsp,
   input  wire                   i_rsp_ready,
   input  wire                   i_ram_init_done,
   input  wire [`IO_GPIO_W-1:0]  i_gpio_in,
   output io_irq_t               o_irq,
   output logic [`IO_GPIO_W-1:0] o_gpio_out,
   output logic [`IO_GPIO_W-1:0] o_gpio_oe
);

   wb_m2s_t wb_m2s;
   wb_s2m_t wb_s2m;
   wb_s2m_t wb_sys;
   wb_s2m_t wb_gpio;
   logic    sys_stb;
   logic    gpio_stb;
   logic    timer_irq;
   logic    sw_irq3;
   logic    sw_irq4;
   logic    gpio_irq;

   io_wb_bridge bridge (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_req_valid (i_req_valid),
      .i_req       (i_req),
      .o_req_ready (o_req_ready),
      .o_rsp_valid (o_rsp_valid),
      .o_rsp       (o_rsp),
      .i_rsp_ready (i_rsp_ready),
      .o_wb        (wb_m2s),
      .i_wb        (wb_s2m));

   io_wb_decode decode (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_wb       (wb_m2s),
      .o_wb       (wb_s2m),
      .o_sys_stb  (sys_stb),
      .o_gpio_stb (gpio_stb),
      .i_sys      (wb_sys),
      .i_gpio     (wb_gpio));

   io_syscon syscon (
      .clk             (clk),
      .i_arst_n        (i_arst_n),
      .i_wb            (wb_m2s),
      .i_stb           (sys_stb),
      .o_wb            (wb_sys),
      .i_ram_init_done (i_ram_init_done),
      .o_timer_irq     (timer_irq),
      .o_sw_irq3       (sw_irq3),
      .o_sw_irq4       (sw_irq4));

   io_gpio gpio (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_wb       (wb_m2s),
      .i_stb      (gpio_stb),
      .o_wb       (wb_gpio),
      .i_gpio_in  (i_gpio_in),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe),
      .o_gpio_irq (gpio_irq));

   assign o_irq = '{timer: timer_irq, sw3: sw_irq3, sw4: sw_irq4, gpio: gpio_irq};

endmodule

`default_nettype wire

// File: logic/io_syscon.sv
// System-control block
// Identification, RAM init status, software interrupts and the
// machine timer with its compare interrupt
`timescale 1ns/1ps
`default_nettype none
`include "io_params.svh"

module io_syscon import io_pkg::*; (
   input  wire          clk,
   input  wire          i_arst_n,
   input  wire wb_m2s_t i_wb,
   input  wire          i_stb,
   output wb_s2m_t      o_wb,
   input  wire          i_ram_init_done,
   output logic         o_timer_irq,
   output logic         o_sw_irq3,
   output logic         o_sw_irq4
);

   logic [1:0]        init_sync_q;
   logic [1:0]        swirq_q;
   logic [`IO_DW-1:0] mtime_q;
   logic [`IO_DW-1:0] mtimecmp_q;
   logic              timer_irq_q;
   logic              ack_q;
   logic [`IO_DW-1:0] rdata_q;
   logic [`IO_DW-1:0] rd_mux;
   logic              acc;
   logic              wr_en;

   assign acc   = i_wb.cyc && i_stb && !ack_q;
   assign wr_en = acc && i_wb.we;

   always_comb begin
      case (i_wb.adr.f.reg_idx)
         `SYS_ID:       rd_mux = `SYS_ID_VALUE;
         `SYS_STATUS:   rd_mux = `IO_DW'(init_sync_q[1]);
         `SYS_SWIRQ:    rd_mux = `IO_DW'(swirq_q);
         `SYS_MTIME:    rd_mux = mtime_q;
         `SYS_MTIMECMP: rd_mux = mtimecmp_q;
         default:       rd_mux = '0;
      endcase
   end

   //*************************************************************************
   // Registers and timer
   //*************************************************************************
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         init_sync_q <= '0;
         swirq_q     <= '0;
         mtime_q     <= '0;
         mtimecmp_q  <= '1;
         timer_irq_q <= 1'b0;
         ack_q       <= 1'b0;
      end else begin
         init_sync_q <= {init_sync_q[0], i_ram_init_done};
         ack_q       <= acc;
         timer_irq_q <= (mtime_q >= mtimecmp_q);

         // Software write wins over the tick
         if (wr_en && (i_wb.adr.f.reg_idx == `SYS_MTIME)) begin
            mtime_q <= strb_merge(mtime_q, i_wb.dat, i_wb.sel);
         end else begin
            mtime_q <= mtime_q + 1'b1;
         end

         if (wr_en && (i_wb.adr.f.reg_idx == `SYS_MTIMECMP)) begin
            mtimecmp_q <= strb_merge(mtimecmp_q, i_wb.dat, i_wb.sel);
         end

         if (wr_en && (i_wb.adr.f.reg_idx == `SYS_SWIRQ) && i_wb.sel[0]) begin
            swirq_q <= i_wb.dat[1:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (acc) begin
         rdata_q <= rd_mux;
      end
   end

   assign o_wb = '{dat: rdata_q, ack: ack_q, err: 1'b0};

   assign o_timer_irq = timer_irq_q;
   assign o_sw_irq3   = swirq_q[0];
   assign o_sw_irq4   = swirq_q[1];

endmodule

`default_nettype wire

// File: logic/io_wb_bridge.sv
// Host to Wishbone bridge
// Runs one single Wishbone cycle per host request and holds the
// response until the host takes it
`timescale 1ns/1ps
`default_nettype none
`include "io_params.svh"

module io_wb_bridge import io_pkg::*; (
   input  wire          clk,
   input  wire          i_arst_n,
   input  wire          i_req_valid,
   input  wire io_req_t i_req,
   output logic         o_req_ready,
   output logic         o_rsp_valid,
   output io_rsp_t      o_rsp,
   input  wire          i_rsp_ready,
   output wb_m2s_t      o_wb,
   input  wire wb_s2m_t i_wb
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_BUS,
      ST_RSP
   } state_e;

   state_e            state_q;
   io_addr_u          adr_q;
   logic [`IO_DW-1:0] dat_q;
   logic [`IO_SW-1:0] sel_q;
   logic              we_q;
   io_rsp_t           rsp_q;
   logic              take;
   logic              done;
   logic              bus;

   assign take = (state_q == ST_IDLE) && i_req_valid;
   assign done = (state_q == ST_BUS) && (i_wb.ack || i_wb.err);
   assign bus  = (state_q == ST_BUS);

   //*************************************************************************
   // Controller
   //*************************************************************************
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (i_req_valid) begin
                  state_q <= ST_BUS;
               end
            end
            ST_BUS: begin
               if (i_wb.ack || i_wb.err) begin
                  state_q <= ST_RSP;
               end
            end
            default: begin
               if (i_rsp_ready) begin
                  state_q <= ST_IDLE;
               end
            end
         endcase
      end
   end

   // Request and response payload
   always_ff @(posedge clk) begin
      if (take) begin
         adr_q <= i_req.addr;
         dat_q <= i_req.wdata;
         sel_q <= i_req.wstrb;
         we_q  <= i_req.we;
      end
      if (done) begin
         rsp_q.rdata <= i_wb.dat;
         rsp_q.err   <= i_wb.err;
      end
   end

   assign o_wb = '{adr: adr_q, dat: dat_q, sel: sel_q, we: we_q, cyc: bus, stb: bus};

   assign o_req_ready = (state_q == ST_IDLE);
   assign o_rsp_valid = (state_q == ST_RSP);
   assign o_rsp       = rsp_q;

endmodule

`default_nettype wire

// File: logic/io_wb_decode.sv
// Wishbone address decoder
// Selects a peripheral by address page and returns its data, errors
// cycles that hit an unmapped page
`timescale 1ns/1ps
`default_nettype none
`include "io_params.svh"

module io_wb_decode import io_pkg::*; (
   input  wire          clk,
   input  wire          i_arst_n,
   input  wire wb_m2s_t i_wb,
   output wb_s2m_t      o_wb,
   output logic         o_sys_stb,
   output logic         o_gpio_stb,
   input  wire wb_s2m_t i_sys,
   input  wire wb_s2m_t i_gpio
);

   logic sys_hit;
   logic gpio_hit;
   logic err_q;

   assign sys_hit  = (i_wb.adr.f.page == `IO_PAGE_SYSCON);
   assign gpio_hit = (i_wb.adr.f.page == `IO_PAGE_GPIO);

   assign o_sys_stb  = i_wb.stb && sys_hit;
   assign o_gpio_stb = i_wb.stb && gpio_hit;

   // Unmapped page terminates with the same latency as a slave
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         err_q <= 1'b0;
      end else begin
         err_q <= i_wb.cyc && i_wb.stb && !sys_hit && !gpio_hit && !err_q;
      end
   end

   //*************************************************************************
   // Return path
   //*************************************************************************
   always_comb begin
      o_wb.ack = i_sys.ack || i_gpio.ack;
      o_wb.err = err_q || i_sys.err || i_gpio.err;
      if (sys_hit) begin
         o_wb.dat = i_sys.dat;
      end else if (gpio_hit) begin
         o_wb.dat = i_gpio.dat;
      end else begin
         o_wb.dat = '0;
      end
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/io_pkg.sv
logic/io_wb_bridge.sv
logic/io_wb_decode.sv
logic/io_syscon.sv
logic/io_gpio.sv
logic/io_soc_top.sv
tb/io_soc_assert.sv
tb/io_soc_checker.sv
tb/tb_io_soc.sv

// File: tb/io_soc_assert.sv
// Handshake assertions for the host to Wishbone bridge
// Bound into the bridge, watches the host ports and the Wishbone master
`timescale 1ns/1ps
`default_nettype none

module io_soc_assert import io_pkg::*; (
   input wire          clk,
   input wire          i_arst_n,
   input wire          i_req_valid,
   input wire          i_req_ready,
   input wire          i_rsp_valid,
   input wire io_rsp_t i_rsp,
   input wire          i_rsp_ready,
   input wire wb_m2s_t i_wb,
   input wire wb_s2m_t i_wb_s2m
);

   int   fail_cnt = 0;
   logic pend_q;

   // Outstanding from acceptance until the host takes the response
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pend_q <= 1'b0;
      end else if (i_req_valid && i_req_ready) begin
         pend_q <= 1'b1;
      end else if (i_rsp_valid && i_rsp_ready) begin
         pend_q <= 1'b0;
      end
   end

   // Held response under back-pressure
   rsp_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_rsp_valid && !i_rsp_ready |=> i_rsp_valid && $stable(i_rsp))
      else begin
         $error("response changed or dropped while the host stalled it");
         fail_cnt++;
      end

   // Strobe stays up inside cyc until the slave terminates
   stb_in_cyc: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_wb.stb && !(i_wb_s2m.ack || i_wb_s2m.err) |=> i_wb.stb && i_wb.cyc)
      else begin
         $error("Wishbone stb dropped or high without cyc before termination");
         fail_cnt++;
      end

   busy_while_rsp: assert property (@(posedge clk) disable iff (!i_arst_n)
      pend_q |-> !i_req_ready)
      else begin
         $error("request port ready while a response is pending");
         fail_cnt++;
      end

   // Fixed latency, accept edge to first valid edge
   rsp_latency: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_req_valid && i_req_ready |=> !i_rsp_valid ##1 !i_rsp_valid ##1 i_rsp_valid)
      else begin
         $error("response did not follow acceptance by three cycles");
         fail_cnt++;
      end

endmodule

`default_nettype wire

// File: tb/io_soc_checker.sv
// Register map model and response checker
// Tracks syscon and GPIO state cycle by cycle and compares responses,
// interrupts and GPIO outputs against it
`timescale 1ns/1ps
`default_nettype none
`include "io_params.svh"

module io_soc_checker import io_pkg::*; (
   input  wire                  clk,
   input  wire                  i_arst_n,
   input  wire                  i_req_valid,
   input  wire io_req_t         i_req,
   input  wire                  i_req_ready,
   input  wire                  i_rsp_valid,
   input  wire io_rsp_t         i_rsp,
   input  wire                  i_rsp_ready,
   input  wire                  i_ram_init_done,
   input  wire [`IO_GPIO_W-1:0] i_gpio_in,
   input  wire io_irq_t         i_irq,
   input  wire [`IO_GPIO_W-1:0] i_gpio_out,
   input  wire [`IO_GPIO_W-1:0] i_gpio_oe,
   output int                   o_errors,
   output int                   o_responses
);

   int                    err_cnt = 0;
   int                    rsp_cnt = 0;
   io_req_t               cur_q;
   logic                  pending_q;
   logic                  bus_phase_q;
   io_rsp_t               exp_q;
   logic [`IO_DW-1:0]     mtime_m;
   logic [`IO_DW-1:0]     mtimecmp_m;
   logic [1:0]            swirq_m;
   logic                  timer_m;
   logic [1:0]            init_m;
   logic [`IO_GPIO_W-1:0] pin1_m;
   logic [`IO_GPIO_W-1:0] pin2_m;
   logic [`IO_GPIO_W-1:0] pin_prev_m;
   logic [`IO_GPIO_W-1:0] out_m;
   logic [`IO_GPIO_W-1:0] oe_m;
   logic [`IO_GPIO_W-1:0] mask_m;
   logic [`IO_GPIO_W-1:0] status_m;
   logic                  gpio_irq_m;
   logic                  wr_sys;
   logic                  wr_gpio;
   logic [`IO_GPIO_W-1:0] clr_v;
   logic [`IO_GPIO_W-1:0] status_v;

   assign o_errors    = err_cnt;
   assign o_responses = rsp_cnt;

   function automatic logic [31:0] merge_lanes(input logic [31:0] cur,
                                               input logic [31:0] wr,
                                               input logic [3:0]  strb);
      logic [31:0] lanes;
      for (int i = 0; i < 4; i++) begin
         lanes[8*i +: 8] = {8{strb[i]}};
      end
      return (cur & ~lanes) | (wr & lanes);
   endfunction

   function automatic io_rsp_t expect_read(input io_addr_u a);
      io_rsp_t r;
      r.err   = 1'b0;
      r.rdata = '0;
      if (a.f.page == `IO_PAGE_SYSCON) begin
         case (a.f.reg_idx)
            `SYS_ID:       r.rdata = `SYS_ID_VALUE;
            `SYS_STATUS:   r.rdata = {31'b0, init_m[1]};
            `SYS_SWIRQ:    r.rdata = {30'b0, swirq_m};
            `SYS_MTIME:    r.rdata = mtime_m;
            `SYS_MTIMECMP: r.rdata = mtimecmp_m;
            default:       r.rdata = '0;
         endcase
      end else if (a.f.page == `IO_PAGE_GPIO) begin
         case (a.f.reg_idx)
            `GPIO_IN:     r.rdata = pin2_m;
            `GPIO_OUT:    r.rdata = out_m;
            `GPIO_OE:     r.rdata = oe_m;
            `GPIO_MASK:   r.rdata = mask_m;
            `GPIO_STATUS: r.rdata = status_m;
            default:      r.rdata = '0;
         endcase
      end else begin
         r.err = 1'b1;
      end
      return r;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (act !== exp) begin
         err_cnt++;
         $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      end
   endtask

   task automatic report_failure(input string msg);
      err_cnt++;
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   always @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pending_q   <= 1'b0;
         bus_phase_q <= 1'b0;
         mtime_m     <= '0;
         mtimecmp_m  <= '1;
         swirq_m     <= '0;
         timer_m     <= 1'b0;
         init_m      <= '0;
         pin1_m      <= '0;
         pin2_m      <= '0;
         pin_prev_m  <= '0;
         out_m       <= '0;
         oe_m        <= '0;
         mask_m      <= '0;
         status_m    <= '0;
         gpio_irq_m  <= 1'b0;
      end else begin
         check_value("o_irq.timer", timer_m, i_irq.timer);
         check_value("o_irq.sw3", swirq_m[0], i_irq.sw3);
         check_value("o_irq.sw4", swirq_m[1], i_irq.sw4);
         check_value("o_irq.gpio", gpio_irq_m, i_irq.gpio);
         check_value("o_gpio_out", out_m, i_gpio_out);
         check_value("o_gpio_oe", oe_m, i_gpio_oe);

         if (i_rsp_valid && i_rsp_ready) begin
            rsp_cnt++;
            if (!pending_q || bus_phase_q) begin
               report_failure("response delivered with no request outstanding");
            end else begin
               check_value("o_rsp.err", exp_q.err, i_rsp.err);
               // Error responses carry zero data for writes too
               if (!cur_q.we || exp_q.err) begin
                  check_value("o_rsp.rdata", exp_q.rdata, i_rsp.rdata);
               end
            end
            pending_q <= 1'b0;
         end

         if (i_req_valid && i_req_ready) begin
            if (pending_q) begin
               report_failure("request accepted while a response was outstanding");
            end
            cur_q       <= i_req;
            pending_q   <= 1'b1;
            bus_phase_q <= 1'b1;
         end

         // Bus phase edge, read sampled and write applied here
         wr_sys  = bus_phase_q && cur_q.we && (cur_q.addr.f.page == `IO_PAGE_SYSCON);
         wr_gpio = bus_phase_q && cur_q.we && (cur_q.addr.f.page == `IO_PAGE_GPIO);
         if (bus_phase_q) begin
            exp_q       <= expect_read(cur_q.addr);
            bus_phase_q <= 1'b0;
         end

         //******************************************************************
         // Syscon
         //******************************************************************
         init_m  <= {init_m[0], i_ram_init_done};
         timer_m <= (mtime_m >= mtimecmp_m);
         mtime_m <= mtime_m + 1;
         if (wr_sys) begin
            case (cur_q.addr.f.reg_idx)
               `SYS_SWIRQ: begin
                  if (cur_q.wstrb[0]) begin
                     swirq_m <= cur_q.wdata[1:0];
                  end
               end
               `SYS_MTIME:    mtime_m <= merge_lanes(mtime_m, cur_q.wdata, cur_q.wstrb);
               `SYS_MTIMECMP: mtimecmp_m <= merge_lanes(mtimecmp_m, cur_q.wdata, cur_q.wstrb);
               default: begin
               end
            endcase
         end

         //******************************************************************
         // GPIO
         //******************************************************************
         pin1_m     <= i_gpio_in;
         pin2_m     <= pin1_m;
         pin_prev_m <= pin2_m;
         clr_v = '0;
         if (wr_gpio && (cur_q.addr.f.reg_idx == `GPIO_STATUS)) begin
            clr_v = merge_lanes('0, cur_q.wdata, cur_q.wstrb);
         end
         status_v   = (status_m & ~clr_v) | (pin2_m & ~pin_prev_m & mask_m);
         status_m   <= status_v;
         gpio_irq_m <= |status_v;
         if (wr_gpio) begin
            case (cur_q.addr.f.reg_idx)
               `GPIO_OUT:  out_m <= merge_lanes(out_m, cur_q.wdata, cur_q.wstrb);
               `GPIO_OE:   oe_m <= merge_lanes(oe_m, cur_q.wdata, cur_q.wstrb);
               `GPIO_MASK: mask_m <= merge_lanes(mask_m, cur_q.wdata, cur_q.wstrb);
               default: begin
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: tb/tb_io_soc.sv
// I/O subsystem testbench
// Directed register checks, then random host traffic with back-pressure
`timescale 1ns/1ps
`default_nettype none
`include "io_params.svh"

module tb_io_soc import io_pkg::*; ();

   localparam int N_RAND     = 300;
   localparam int N_DIRECTED = 31;
   localparam int N_REQ      = N_RAND + N_DIRECTED;
   localparam int MAX_CYC    = 20 * N_REQ + 200;

   logic                  clk;
   logic                  i_arst_n;
   logic                  i_req_valid;
   io_req_t               i_req;
   logic                  o_req_ready;
   logic                  o_rsp_valid;
   io_rsp_t               o_rsp;
   logic                  i_rsp_ready;
   logic                  i_ram_init_done;
   logic [`IO_GPIO_W-1:0] i_gpio_in;
   io_irq_t               o_irq;
   logic [`IO_GPIO_W-1:0] o_gpio_out;
   logic [`IO_GPIO_W-1:0] o_gpio_oe;
   int                    chk_errors;
   int                    chk_rsps;
   int                    sent = 0;
   int                    cycles = 0;
   logic                  bp_on;
   logic                  gpio_rand;

   io_soc_top io_soc_top_i (
      .clk             (clk),
      .i_arst_n        (i_arst_n),
      .i_req_valid     (i_req_valid),
      .i_req           (i_req),
      .o_req_ready     (o_req_ready),
      .o_rsp_valid     (o_rsp_valid),
      .o_rsp           (o_rsp),
      .i_rsp_ready     (i_rsp_ready),
      .i_ram_init_done (i_ram_init_done),
      .i_gpio_in       (i_gpio_in),
      .o_irq           (o_irq),
      .o_gpio_out      (o_gpio_out),
      .o_gpio_oe       (o_gpio_oe));

   io_soc_checker model_check (
      .clk             (clk),
      .i_arst_n        (i_arst_n),
      .i_req_valid     (i_req_valid),
      .i_req           (i_req),
      .i_req_ready     (o_req_ready),
      .i_rsp_valid     (o_rsp_valid),
      .i_rsp           (o_rsp),
      .i_rsp_ready     (i_rsp_ready),
      .i_ram_init_done (i_ram_init_done),
      .i_gpio_in       (i_gpio_in),
      .i_irq           (o_irq),
      .i_gpio_out      (o_gpio_out),
      .i_gpio_oe       (o_gpio_oe),
      .o_errors        (chk_errors),
      .o_responses     (chk_rsps));

   bind io_wb_bridge io_soc_assert bridge_assert (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_req_valid (i_req_valid),
      .i_req_ready (o_req_ready),
      .i_rsp_valid (o_rsp_valid),
      .i_rsp       (o_rsp),
      .i_rsp_ready (i_rsp_ready),
      .i_wb        (o_wb),
      .i_wb_s2m    (i_wb));

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYC) begin
         $display("Timeout: run stopped after %0d cycles without finishing", cycles);
         $display("*** FAILED ***");
         $finish;
      end
   end

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // One host request, returns once it has been accepted
   task automatic send(input logic we, input logic [3:0] page, input logic [3:0] reg_idx,
                       input logic [31:0] wdata, input logic [3:0] wstrb);
      io_req_t     r;
      logic [31:0] rnd;
      rnd                = $urandom;
      r.we               = we;
      r.addr.f.page      = page;
      r.addr.f.spare     = rnd[5:0];
      r.addr.f.reg_idx   = reg_idx;
      r.addr.f.byte_ofs  = 2'b00;
      r.wdata            = wdata;
      r.wstrb            = wstrb;
      @(negedge clk);
      i_req       = r;
      i_req_valid = 1'b1;
      while (!o_req_ready) begin
         @(negedge clk);
      end
      @(negedge clk);
      i_req_valid = 1'b0;
      sent++;
   endtask

   initial begin
      logic [31:0] rnd;
      logic [31:0] data;
      logic [3:0]  ofs;
      logic [3:0]  page;
      void'($urandom(32'h9608_f85b));
      clk             = 1'b0;
      i_arst_n        = 1'b0;
      i_req_valid     = 1'b0;
      i_req           = '0;
      i_rsp_ready     = 1'b1;
      i_ram_init_done = 1'b0;
      i_gpio_in       = '0;
      bp_on           = 1'b0;
      gpio_rand       = 1'b0;

      // Host back-pressure and pin noise
      fork
         forever begin
            @(negedge clk);
            i_rsp_ready = !bp_on || ($urandom_range(3) != 0);
            if (gpio_rand && ($urandom_range(7) == 0)) begin
               i_gpio_in = i_gpio_in ^ (32'h1 << $urandom_range(31));
            end
         end
      join_none

      repeat (16) @(negedge clk);
      i_arst_n = 1'b1;

      // ID and RAM init status
      send(1'b0, `IO_PAGE_SYSCON, `SYS_ID, '0, 4'hf);
      i_ram_init_done = 1'b1;
      wait_cycles(4);
      send(1'b0, `IO_PAGE_SYSCON, `SYS_STATUS, '0, 4'hf);
      i_ram_init_done = 1'b0;
      wait_cycles(4);
      send(1'b0, `IO_PAGE_SYSCON, `SYS_STATUS, '0, 4'hf);

      // Strobed GPIO registers, read-only and unknown offsets
      for (ofs = `GPIO_OUT; ofs <= `GPIO_MASK; ofs++) begin
         data = $urandom;
         rnd  = $urandom;
         send(1'b1, `IO_PAGE_GPIO, ofs, data, rnd[3:0]);
         send(1'b0, `IO_PAGE_GPIO, ofs, '0, 4'hf);
      end
      send(1'b1, `IO_PAGE_GPIO, `GPIO_IN, 32'hffff_ffff, 4'hf);
      send(1'b1, `IO_PAGE_GPIO, 4'd7, 32'hffff_ffff, 4'hf);
      send(1'b0, `IO_PAGE_GPIO, `GPIO_IN, '0, 4'hf);
      send(1'b0, `IO_PAGE_GPIO, 4'd7, '0, 4'hf);
      send(1'b1, `IO_PAGE_SYSCON, `SYS_ID, 32'h0, 4'hf);
      send(1'b0, `IO_PAGE_SYSCON, `SYS_ID, '0, 4'hf);

      // Unmapped pages
      send(1'b0, 4'd5, 4'd0, '0, 4'hf);
      send(1'b1, 4'd9, 4'd1, 32'h1234_5678, 4'hf);
      send(1'b0, `IO_PAGE_SYSCON, `SYS_ID, '0, 4'hf);

      // Software and timer interrupts
      send(1'b1, `IO_PAGE_SYSCON, `SYS_SWIRQ, 32'h3, 4'h1);
      send(1'b1, `IO_PAGE_SYSCON, `SYS_SWIRQ, 32'h2, 4'h1);
      send(1'b1, `IO_PAGE_SYSCON, `SYS_SWIRQ, 32'h0, 4'h1);
      send(1'b1, `IO_PAGE_SYSCON, `SYS_MTIME, 32'd1000, 4'hf);
      send(1'b1, `IO_PAGE_SYSCON, `SYS_MTIMECMP, 32'd10, 4'hf);
      wait_cycles(6);
      send(1'b1, `IO_PAGE_SYSCON, `SYS_MTIMECMP, 32'hffff_ffff, 4'hf);
      wait_cycles(3);
      send(1'b0, `IO_PAGE_SYSCON, `SYS_MTIME, '0, 4'hf);
      send(1'b0, `IO_PAGE_SYSCON, `SYS_MTIME, '0, 4'hf);

      // Edge interrupt on pin 4, pin 0 left unmasked
      send(1'b1, `IO_PAGE_GPIO, `GPIO_MASK, 32'h0000_0010, 4'hf);
      wait_cycles(6);
      i_gpio_in = 32'h0000_0010;
      wait_cycles(6);
      send(1'b0, `IO_PAGE_GPIO, `GPIO_STATUS, '0, 4'hf);
      i_gpio_in = 32'h0000_0011;
      wait_cycles(6);
      send(1'b0, `IO_PAGE_GPIO, `GPIO_STATUS, '0, 4'hf);
      send(1'b1, `IO_PAGE_GPIO, `GPIO_STATUS, 32'h0000_0010, 4'hf);
      wait_cycles(3);
      send(1'b0, `IO_PAGE_GPIO, `GPIO_STATUS, '0, 4'hf);

      //**********************************************************************
      // Random traffic
      //**********************************************************************
      bp_on     = 1'b1;
      gpio_rand = 1'b1;
      for (int k = 0; k < N_RAND; k++) begin
         rnd  = $urandom;
         data = $urandom;
         page = (rnd[7:5] == 3'd0) ? rnd[3:0] : {3'b000, rnd[4]};
         send(rnd[15], page, {1'b0, rnd[10:8]}, data, rnd[14:11]);
         wait_cycles(rnd[17:16]);
      end

      bp_on = 1'b0;
      while (!o_req_ready) begin
         @(negedge clk);
      end
      wait_cycles(4);
      $display("Requests %0d, responses %0d, check errors %0d, assertion failures %0d",
               sent, chk_rsps, chk_errors, io_soc_top_i.bridge.bridge_assert.fail_cnt);
      if (chk_errors == 0 && chk_rsps == sent &&
          io_soc_top_i.bridge.bridge_assert.fail_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         if (chk_rsps != sent) begin
            $display("Number of responses differs from number of accepted requests");
         end
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
